// File: rtl/l1_tag_pkg.sv
// L1 tag package with the cache geometry, the fill latency and the tag and miss record types
`default_nettype none

package l1_tag_pkg;

	// Request address, split into a tag on top and a set index at the bottom
	localparam int ADDR_WIDTH = 26;
	localparam int SET_INDEX_WIDTH = 5;
	localparam int NUM_SETS = 1 << SET_INDEX_WIDTH;
	localparam int TAG_WIDTH = ADDR_WIDTH - SET_INDEX_WIDTH;

	// Four-way associativity, so a way index fits in two bits
	localparam int NUM_WAYS = 4;
	localparam int WAY_WIDTH = 2;

	// Cycles the fill sequencer waits for memory on every fill
	localparam int FILL_LATENCY = 4;

	// Width of the down counter that spans the fill latency
	localparam int LATENCY_COUNT_WIDTH = $clog2(FILL_LATENCY);

	// Number of misses that can wait for the fill sequencer
	localparam int MISS_QUEUE_DEPTH = 4;

	// Index of one way within a set
	typedef logic [WAY_WIDTH-1:0] way_t;

	// One word of a tag memory
	// The valid bit sits on top so a cleared word is an invalid line
	typedef struct packed {
		logic                 valid;
		logic [TAG_WIDTH-1:0] tag;
	} tag_entry_t;

	// A line that missed, as queued for the fill and as reported when it lands
	typedef struct packed {
		logic [SET_INDEX_WIDTH-1:0] set;
		logic [TAG_WIDTH-1:0]       tag;
	} miss_req_t;

endpackage

`default_nettype wire

// File: rtl/tag_update_if.sv
// Tag update interface carrying fill writes and whole-set invalidations into the tag block
`timescale 1ns/1ps
`default_nettype none

interface tag_update_if;
	import l1_tag_pkg::*;

	// Fill write of {valid=1, tag} into one way of a set
	logic                       update;
	// Clears the valid bit of all four ways of a set
	logic                       invalidate_set;
	// Way written by a fill, ignored by an invalidation
	way_t                       way;
	// Set addressed by either operation
	logic [SET_INDEX_WIDTH-1:0] set;
	// Tag installed by a fill
	logic [TAG_WIDTH-1:0]       tag;

	// The fill sequencer drives the update
	modport master (output update, invalidate_set, way, set, tag);

	// The tag block applies it at the next rising edge
	modport slave (input update, invalidate_set, way, set, tag);

endinterface

`default_nettype wire

// File: rtl/sram_1r1w.sv
// Synchronous memory with one registered read port and one write port
`timescale 1ns/1ps
`default_nettype none

module sram_1r1w
	#(parameter type data_t = logic [7:0],
	parameter int DEPTH = 32)
	(input wire logic                     clk,
	input wire logic                      reset,
	input wire logic                      rd_enable_i,
	input wire logic [$clog2(DEPTH)-1:0]  rd_addr_i,
	input wire logic                      wr_enable_i,
	input wire logic [$clog2(DEPTH)-1:0]  wr_addr_i,
	input wire data_t                     wr_data_i,
	output data_t                         rd_data_o);

	// Storage array
	data_t mem [DEPTH];

	// The write lands at the clock edge
	always_ff @(posedge clk)
	begin
		if (wr_enable_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// Registered read with one cycle of latency
	// The read samples the array before the write of the same edge lands,
	// so a read and a write to one address in the same cycle return the old word
	// The output register comes out of reset as all zeros, which is an empty
	// word for the tag memories
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rd_data_o <= '0;
		else if (rd_enable_i)
			rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

// File: rtl/l1_cache_tag.sv
// Four-way tag lookup that reads every way in parallel, reports hit and way and emits misses
`timescale 1ns/1ps
`default_nettype none

module l1_cache_tag
	(input wire logic                          clk,
	input wire logic                           reset,
	input wire logic                           access_i,
	input wire logic [l1_tag_pkg::ADDR_WIDTH-1:0] request_addr_i,
	tag_update_if.slave                        upd,
	output logic                               cache_hit_o,
	output l1_tag_pkg::way_t                   hit_way_o,
	output logic                               miss_valid_o,
	output l1_tag_pkg::miss_req_t              miss_req_o);

	import l1_tag_pkg::*;

	// Address split for the request in the current cycle
	logic [SET_INDEX_WIDTH-1:0] request_set;
	logic [TAG_WIDTH-1:0]       request_tag;

	// Request state held over the one cycle of sram read latency
	logic                       access_latched;
	logic [SET_INDEX_WIDTH-1:0] request_set_latched;
	logic [TAG_WIDTH-1:0]       request_tag_latched;

	// Word written into the tag memories and the per-way write enables
	tag_entry_t                 write_entry;
	logic [NUM_WAYS-1:0]        way_write;

	// Words read back from each way and the resulting one-hot hit vector
	tag_entry_t                 way_entry [NUM_WAYS];
	logic [NUM_WAYS-1:0]        way_hit;
	logic                       any_hit;

	// Set index from the low address bits, tag from the rest
	assign request_set = request_addr_i[SET_INDEX_WIDTH-1:0];
	assign request_tag = request_addr_i[ADDR_WIDTH-1:SET_INDEX_WIDTH];

	// A fill writes a valid line and an invalidation writes an empty one
	// Only the valid bit matters for an invalidated word
	assign write_entry = '{valid: upd.update, tag: upd.tag};

	for (genvar w = 0; w < NUM_WAYS; w++)
	begin : gen_way
		// A fill writes only its own way, an invalidation writes all of them
		assign way_write[w] = (upd.update && upd.way == way_t'(w)) || upd.invalidate_set;

		sram_1r1w #(
			.data_t(tag_entry_t),
			.DEPTH(NUM_SETS)
		) tag_mem (
			.clk(clk),
			.reset(reset),
			.rd_enable_i(access_i),
			.rd_addr_i(request_set),
			.wr_enable_i(way_write[w]),
			.wr_addr_i(upd.set),
			.wr_data_i(write_entry),
			.rd_data_o(way_entry[w])
		);

		// Compare the stored tag against the tag of last cycle's request
		assign way_hit[w] = way_entry[w].valid && way_entry[w].tag == request_tag_latched;
	end

	// Only the access strobe is control state
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			access_latched <= 1'b0;
		else
			access_latched <= access_i;
	end

	// Set and tag follow the read into the compare stage
	always_ff @(posedge clk)
	begin
		request_set_latched <= request_set;
		request_tag_latched <= request_tag;
	end

	assign any_hit = |way_hit;

	// Hits count only in the cycle after an access
	assign cache_hit_o = access_latched && any_hit;

	// One-hot to index, valid as long as at most one way matches
	assign hit_way_o = {way_hit[3] | way_hit[2], way_hit[3] | way_hit[1]};

	// An access that found no way becomes a miss record for the queue
	assign miss_valid_o = access_latched && !any_hit;
	assign miss_req_o = '{set: request_set_latched, tag: request_tag_latched};

endmodule

`default_nettype wire

// File: rtl/miss_fifo.sv
// In-order circular queue of miss records with empty and full levels
`timescale 1ns/1ps
`default_nettype none

module miss_fifo
	#(parameter type data_t = logic [7:0],
	parameter int DEPTH = 4)
	(input wire logic  clk,
	input wire logic   reset,
	input wire logic   push_i,
	input wire data_t  push_data_i,
	input wire logic   pop_i,
	output data_t      head_o,
	output logic       empty_o,
	output logic       full_o);

	// Entry storage
	data_t mem [DEPTH];

	// Read and write positions and the number of entries held
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;

	// Every slot taken
	logic                       queue_full;

	// Transfers that actually happen
	logic                       do_push;
	logic                       do_pop;

	assign queue_full = count == DEPTH;
	assign empty_o = count == 0;

	// A push while full or a pop while empty would corrupt the count, so both are dropped
	assign do_push = push_i && !queue_full;
	assign do_pop = pop_i && !empty_o;

	// The miss of an access shows up one cycle after the access, so the
	// requester sees the queue as full as soon as the miss arriving now
	// takes the last slot
	// An access issued while this is low can always be queued
	assign full_o = (count + push_i) >= DEPTH;

	assign head_o = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data_i;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
			begin
				if (wr_ptr == DEPTH - 1)
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end

			if (do_pop)
			begin
				if (rd_ptr == DEPTH - 1)
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end

			// A simultaneous push and pop leaves the occupancy unchanged
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/fill_sequencer.sv
// Fill sequencer that pops misses, waits out memory latency and installs tags round robin
`timescale 1ns/1ps
`default_nettype none

module fill_sequencer
	(input wire logic                               clk,
	input wire logic                                reset,
	input wire logic                                empty_i,
	input wire l1_tag_pkg::miss_req_t               head_i,
	input wire logic                                invalidate_set_i,
	input wire logic [l1_tag_pkg::SET_INDEX_WIDTH-1:0] invalidate_index_i,
	output logic                                    pop_o,
	output logic                                    fill_done_o,
	output l1_tag_pkg::way_t                        fill_way_o,
	tag_update_if.master                            upd);

	import l1_tag_pkg::*;

	typedef enum logic [1:0] {
		STATE_IDLE,
		STATE_WAIT,
		STATE_WRITE
	} fill_state_t;

	fill_state_t                    state;
	logic [LATENCY_COUNT_WIDTH-1:0] latency_count;

	// Miss being filled, held from the pop until the write
	miss_req_t                      fill_req;

	// Next victim way of every set
	way_t                           rr_ptr [NUM_SETS];

	// Take the next miss only when idle, and never in a cycle that carries an invalidation
	assign pop_o = state == STATE_IDLE && !empty_i && !invalidate_set_i;

	// An invalidation owns the update port, so the write waits one more cycle
	assign fill_done_o = state == STATE_WRITE && !invalidate_set_i;

	// The victim is whatever the set's pointer names at write time
	assign fill_way_o = rr_ptr[fill_req.set];

	assign upd.update = fill_done_o;
	assign upd.invalidate_set = invalidate_set_i;
	assign upd.way = fill_way_o;
	assign upd.set = invalidate_set_i ? invalidate_index_i : fill_req.set;
	assign upd.tag = fill_req.tag;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= STATE_IDLE;
			latency_count <= '0;
		end
		else
		begin
			case (state)
				STATE_IDLE:
				begin
					// Count FILL_LATENCY wait cycles down to zero
					if (pop_o)
					begin
						state <= STATE_WAIT;
						latency_count <= LATENCY_COUNT_WIDTH'(FILL_LATENCY - 1);
					end
				end

				STATE_WAIT:
				begin
					if (latency_count == '0)
						state <= STATE_WRITE;
					else
						latency_count <= latency_count - 1'b1;
				end

				STATE_WRITE:
				begin
					// Stay here through a cycle taken by an invalidation
					if (fill_done_o)
						state <= STATE_IDLE;
				end

				default:
					state <= STATE_IDLE;
			endcase
		end
	end

	// The popped record is payload and needs no reset
	always_ff @(posedge clk)
	begin
		if (pop_o)
			fill_req <= head_i;
	end

	// Each set's pointer moves to the next way after a fill to that set
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int s = 0; s < NUM_SETS; s++)
				rr_ptr[s] <= '0;
		end
		else if (fill_done_o)
			rr_ptr[fill_req.set] <= rr_ptr[fill_req.set] + 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/l1_tag_subsystem.sv
// L1 tag subsystem joining tag lookup, miss queue and fill sequencer behind plain ports
`timescale 1ns/1ps
`default_nettype none

module l1_tag_subsystem
	(input wire logic                                 clk,
	input wire logic                                  reset,
	input wire logic                                  access_i,
	input wire logic [l1_tag_pkg::ADDR_WIDTH-1:0]     request_addr_i,
	input wire logic                                  invalidate_set_i,
	input wire logic [l1_tag_pkg::SET_INDEX_WIDTH-1:0] invalidate_index_i,
	output logic                                      cache_hit_o,
	output l1_tag_pkg::way_t                          hit_way_o,
	output logic                                      miss_queue_full_o,
	output logic                                      fill_done_o,
	output logic [l1_tag_pkg::SET_INDEX_WIDTH-1:0]    fill_set_o,
	output logic [l1_tag_pkg::TAG_WIDTH-1:0]          fill_tag_o,
	output l1_tag_pkg::way_t                          fill_way_o);

	import l1_tag_pkg::*;

	// Fill writes and invalidations from the sequencer into the tag block
	tag_update_if upd ();

	// Miss records from the lookup into the queue
	logic      miss_valid;
	miss_req_t miss_req;

	// Queue head and levels toward the sequencer
	logic      miss_pop;
	miss_req_t miss_head;
	logic      miss_empty;

	l1_cache_tag cache_tag (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.request_addr_i(request_addr_i),
		.upd(upd.slave),
		.cache_hit_o(cache_hit_o),
		.hit_way_o(hit_way_o),
		.miss_valid_o(miss_valid),
		.miss_req_o(miss_req)
	);

	miss_fifo #(
		.data_t(miss_req_t),
		.DEPTH(MISS_QUEUE_DEPTH)
	) miss_queue (
		.clk(clk),
		.reset(reset),
		.push_i(miss_valid),
		.push_data_i(miss_req),
		.pop_i(miss_pop),
		.head_o(miss_head),
		.empty_o(miss_empty),
		.full_o(miss_queue_full_o)
	);

	fill_sequencer fill_seq (
		.clk(clk),
		.reset(reset),
		.empty_i(miss_empty),
		.head_i(miss_head),
		.invalidate_set_i(invalidate_set_i),
		.invalidate_index_i(invalidate_index_i),
		.pop_o(miss_pop),
		.fill_done_o(fill_done_o),
		.fill_way_o(fill_way_o),
		.upd(upd.master)
	);

	// During a fill report the update port carries the filled set and tag
	assign fill_set_o = upd.set;
	assign fill_tag_o = upd.tag;

endmodule

`default_nettype wire

// File: sim/l1_cache_tag_properties.sv
// Bound checks on the tag block, its update port and the miss queue it feeds
`timescale 1ns/1ps
`default_nettype none

module l1_cache_tag_properties
	(input wire logic                          clk,
	input wire logic                           reset,
	input wire logic                           access_latched,
	input wire logic [l1_tag_pkg::NUM_WAYS-1:0] way_hit,
	input wire logic                           update,
	input wire logic                           invalidate_set,
	input wire logic                           push,
	input wire logic                           queue_full);

	// Number of assertion failures so far, read by the testbench
	int failure_count = 0;

	// A line lives in at most one way, so a lookup never matches twice
	multi_hit : assert property (@(posedge clk) disable iff (reset)
		access_latched |-> $onehot0(way_hit))
	else
	begin
		failure_count++;
		$error("more than one way matched the looked up tag");
	end

	// The sequencer gives the update port to one operation per cycle
	update_collision : assert property (@(posedge clk) disable iff (reset)
		!(update && invalidate_set))
	else
	begin
		failure_count++;
		$error("fill write and set invalidation in the same cycle");
	end

	// A miss arriving at a queue with every slot taken would be dropped
	push_while_full : assert property (@(posedge clk) disable iff (reset)
		!(push && queue_full))
	else
	begin
		failure_count++;
		$error("miss record pushed into a full miss queue");
	end

endmodule

// Attached at the subsystem so the queue level sits next to the tag block signals
bind l1_tag_subsystem l1_cache_tag_properties props (
	.clk(clk),
	.reset(reset),
	.access_latched(cache_tag.access_latched),
	.way_hit(cache_tag.way_hit),
	.update(upd.update),
	.invalidate_set(upd.invalidate_set),
	.push(miss_valid),
	.queue_full(miss_queue.queue_full)
);

`default_nettype wire

// File: sim/tb_l1_tag.sv
// Random testbench for the L1 tag subsystem with a reference model of tags and fills
`timescale 1ns/1ps
`default_nettype none

module tb_l1_tag;
	import l1_tag_pkg::*;

	localparam logic [31:0] RANDOM_SEED = 32'h272776f0;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_CYCLES = 2000;
	// Five lines into one set, then the same five again
	localparam int DIRECTED_LINES = 5;
	localparam int DIRECTED_CYCLES = 2 * DIRECTED_LINES * (FILL_LATENCY + 3);
	localparam int STIM_CYCLES = RESET_CYCLES + NUM_SETS + DIRECTED_CYCLES + RANDOM_CYCLES;
	localparam int DRAIN_CYCLES = MISS_QUEUE_DEPTH * (FILL_LATENCY + 2);
	localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + DRAIN_CYCLES;
	localparam logic [SET_INDEX_WIDTH-1:0] DIRECTED_SET = 5'd7;
	localparam logic [TAG_WIDTH-1:0] TAG_BASE = 21'h0a5c0;

	logic                       clk;
	logic                       reset;
	logic                       access_i;
	logic [ADDR_WIDTH-1:0]      request_addr_i;
	logic                       invalidate_set_i;
	logic [SET_INDEX_WIDTH-1:0] invalidate_index_i;
	logic                       cache_hit_o;
	way_t                       hit_way_o;
	logic                       miss_queue_full_o;
	logic                       fill_done_o;
	logic [SET_INDEX_WIDTH-1:0] fill_set_o;
	logic [TAG_WIDTH-1:0]       fill_tag_o;
	way_t                       fill_way_o;

	// Reference model of the tag memories and the victim pointers
	logic                       model_valid [NUM_SETS][NUM_WAYS];
	logic [TAG_WIDTH-1:0]       model_tag [NUM_SETS][NUM_WAYS];
	way_t                       model_rr [NUM_SETS];
	// Misses in issue order, queued or in flight
	miss_req_t                  pending [$];
	// Expected result of the access issued last cycle
	logic                       prev_access;
	logic                       prev_hit;
	way_t                       prev_way;
	logic                       seen_full;
	int                         cycle_count = 0;

	l1_tag_subsystem dut (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.request_addr_i(request_addr_i),
		.invalidate_set_i(invalidate_set_i),
		.invalidate_index_i(invalidate_index_i),
		.cache_hit_o(cache_hit_o),
		.hit_way_o(hit_way_o),
		.miss_queue_full_o(miss_queue_full_o),
		.fill_done_o(fill_done_o),
		.fill_set_o(fill_set_o),
		.fill_tag_o(fill_tag_o),
		.fill_way_o(fill_way_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// Guard against a stuck fill or a lost miss
	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %0b actual %0b", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_way(input string name, input way_t expected, input way_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected way %0d actual way %0d", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_miss(input string name, input miss_req_t expected,
			input miss_req_t actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected set %0d tag %h actual set %0d tag %h", name,
				expected.set, expected.tag, actual.set, actual.tag);
			abort_run();
		end
	endtask

	// Pool of four sets so the random lines collide and evict
	function automatic logic [SET_INDEX_WIDTH-1:0] pool_set(input int idx);
		case (idx)
			0: return 5'd3;
			1: return 5'd12;
			2: return 5'd21;
			default: return 5'd30;
		endcase
	endfunction

	function automatic logic [ADDR_WIDTH-1:0] make_line(input logic [SET_INDEX_WIDTH-1:0] set,
			input logic [TAG_WIDTH-1:0] tag);
		return {tag, set};
	endfunction

	function automatic logic line_pending(input logic [ADDR_WIDTH-1:0] addr);
		foreach (pending[i])
			if (make_line(pending[i].set, pending[i].tag) == addr)
				return 1'b1;
		return 1'b0;
	endfunction

	// Drives one cycle from a falling edge and checks outputs before the rising edge
	// The model sees this cycle's fill and invalidation only after the lookup is predicted,
	// since the memories land both writes at the coming edge
	task automatic apply_cycle(input logic do_access, input logic [ADDR_WIDTH-1:0] addr,
			input logic do_inval, input logic [SET_INDEX_WIDTH-1:0] inval_set);
		logic [SET_INDEX_WIDTH-1:0] set;
		logic [TAG_WIDTH-1:0]       tag;
		miss_req_t                  expected_fill;
		miss_req_t                  actual_fill;
		access_i = do_access;
		request_addr_i = addr;
		invalidate_set_i = do_inval;
		invalidate_index_i = inval_set;
		#2;
		if (dut.props.failure_count != 0)
		begin
			$display("A bound assertion on the tag subsystem fired");
			abort_run();
		end
		if (prev_access)
		begin
			check_bit("lookup hit", prev_hit, cache_hit_o);
			if (prev_hit)
				check_way("lookup way", prev_way, hit_way_o);
		end
		else
			check_bit("hit without access", 1'b0, cache_hit_o);
		// Misses still owed a fill are the queued ones, the one arriving now and at most
		// one in flight, so their number bounds the queue level
		if (pending.size() < MISS_QUEUE_DEPTH)
			check_bit("queue full level", 1'b0, miss_queue_full_o);
		else if (pending.size() > MISS_QUEUE_DEPTH)
			check_bit("queue full level", 1'b1, miss_queue_full_o);
		set = addr[SET_INDEX_WIDTH-1:0];
		tag = addr[ADDR_WIDTH-1:SET_INDEX_WIDTH];
		prev_access = do_access;
		prev_hit = 1'b0;
		prev_way = '0;
		if (do_access)
		begin
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				if (model_valid[set][w] && model_tag[set][w] == tag)
				begin
					prev_hit = 1'b1;
					prev_way = way_t'(w);
				end
			end
			// A miss joins the fill order right away, so it also counts as in flight
			if (!prev_hit)
				pending.push_back('{set: set, tag: tag});
		end
		if (fill_done_o)
		begin
			if (pending.size() == 0)
			begin
				$display("A fill was reported while no miss was outstanding");
				abort_run();
			end
			else
			begin
				expected_fill = pending.pop_front();
				actual_fill = '{set: fill_set_o, tag: fill_tag_o};
				check_miss("fill record", expected_fill, actual_fill);
				check_way("fill way", model_rr[expected_fill.set], fill_way_o);
				model_valid[expected_fill.set][model_rr[expected_fill.set]] = 1'b1;
				model_tag[expected_fill.set][model_rr[expected_fill.set]] = expected_fill.tag;
				model_rr[expected_fill.set] = model_rr[expected_fill.set] + 1'b1;
			end
		end
		if (do_inval)
			for (int w = 0; w < NUM_WAYS; w++)
				model_valid[inval_set][w] = 1'b0;
	endtask

	// Idle until every outstanding miss has been filled
	task automatic drain_queue();
		while (pending.size() != 0)
		begin
			@(negedge clk);
			apply_cycle(1'b0, '0, 1'b0, '0);
		end
	endtask

	initial
	begin
		logic [ADDR_WIDTH-1:0]      addr;
		logic                       want_access;
		logic                       do_inval;
		logic [SET_INDEX_WIDTH-1:0] inval_set;
		void'($urandom(RANDOM_SEED));
		reset = 1'b1;
		access_i = 1'b0;
		request_addr_i = '0;
		invalidate_set_i = 1'b0;
		invalidate_index_i = '0;
		prev_access = 1'b0;
		prev_hit = 1'b0;
		prev_way = '0;
		seen_full = 1'b0;
		for (int s = 0; s < NUM_SETS; s++)
		begin
			model_rr[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				model_valid[s][w] = 1'b0;
				model_tag[s][w] = '0;
			end
		end
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		check_bit("reset hit", 1'b0, cache_hit_o);
		check_bit("reset fill", 1'b0, fill_done_o);
		check_bit("reset queue full", 1'b0, miss_queue_full_o);
		// Sram contents are unknown, so every set is cleared first
		for (int s = 0; s < NUM_SETS; s++)
		begin
			@(negedge clk);
			apply_cycle(1'b0, '0, 1'b1, SET_INDEX_WIDTH'(s));
		end
		// Five fills into one set wrap the pointer, the second pass finds the evicted line
		for (int pass = 0; pass < 2; pass++)
		begin
			for (int i = 0; i < DIRECTED_LINES; i++)
			begin
				@(negedge clk);
				apply_cycle(1'b1, make_line(DIRECTED_SET, TAG_BASE + TAG_WIDTH'(i)), 1'b0, '0);
				if (pass == 0)
					drain_queue();
			end
		end
		drain_queue();
		// Dense random traffic so the queue fills and invalidations hit pending fills
		for (int c = 0; c < RANDOM_CYCLES; c++)
		begin
			@(negedge clk);
			want_access = ($urandom % 4) != 0;
			addr = make_line(pool_set($urandom % 4), TAG_BASE + TAG_WIDTH'($urandom % 8));
			do_inval = ($urandom % 48) == 0;
			inval_set = pool_set($urandom % 4);
			if (miss_queue_full_o)
			begin
				seen_full = 1'b1;
				want_access = 1'b0;
			end
			if (line_pending(addr))
				want_access = 1'b0;
			apply_cycle(want_access, addr, do_inval, inval_set);
		end
		drain_queue();
		// One more cycle checks the last lookup
		@(negedge clk);
		apply_cycle(1'b0, '0, 1'b0, '0);
		if (seen_full)
		begin
			$display("Everything OK");
			$finish;
		end
		else
		begin
			$display("The miss queue never reported full during the random traffic");
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: sim.f
rtl/l1_tag_pkg.sv
rtl/tag_update_if.sv
rtl/sram_1r1w.sv
rtl/l1_cache_tag.sv
rtl/miss_fifo.sv
rtl/fill_sequencer.sv
rtl/l1_tag_subsystem.sv
sim/l1_cache_tag_properties.sv
sim/tb_l1_tag.sv

// File: run.sh
#!/bin/sh
# Builds and runs the L1 tag testbench with Verilator, then checks the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_l1_tag \
	-f sim.f -o tb_l1_tag || exit 1
./obj_dir/tb_l1_tag +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Everything OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
